// ==== design/risc_pkg.sv ====
package risc_pkg;

  // datapath widths
  localparam int word_w    = 16;  // data and instruction word
  localparam int addr_w    = 9;   // 512-word memory, also pc width
  localparam int reg_idx_w = 3;   // r0..r7

  // instruction field positions, low bit of each field
  localparam int opcode_lsb = 13;  // [15:13]
  localparam int op_lsb     = 11;  // [12:11]
  localparam int rn_lsb     = 8;   // [10:8], also branch cond
  localparam int rd_lsb     = 5;   // [7:5]
  localparam int sh_lsb     = 3;   // [4:3]
  localparam int rm_lsb     = 0;   // [2:0]
  localparam int imm5_w     = 5;   // ldr/str offset
  localparam int imm8_w     = 8;   // mov imm and branch offset

  // instruction class in the top three bits
  typedef enum logic [2:0] {
    opc_branch = 3'b001,
    opc_ldr    = 3'b011,
    opc_str    = 3'b100,
    opc_alu    = 3'b101,
    opc_mov    = 3'b110,
    opc_halt   = 3'b111
  } opcode_e;

  typedef enum logic [1:0] {
    alu_add = 2'b00,
    alu_cmp = 2'b01,  // subtract, flags only
    alu_and = 2'b10,
    alu_mvn = 2'b11   // invert second operand
  } alu_op_e;

  // one-place shifts of the b operand
  typedef enum logic [1:0] {
    sh_none, sh_lsl, sh_lsr, sh_asr
  } shift_e;

  // branch condition sits in the rn field
  typedef enum logic [2:0] {
    cond_al, cond_eq, cond_ne, cond_lt, cond_le
  } cond_e;

  typedef enum logic [1:0] {
    mem_none, mem_read, mem_write
  } mem_cmd_e;

  typedef enum logic [1:0] {
    sel_rn, sel_rd, sel_rm
  } reg_sel_e;

  // register write-back source
  typedef enum logic [1:0] {
    wb_alu, wb_imm, wb_mem
  } wb_sel_e;

  typedef enum logic [4:0] {
    st_reset, st_if1, st_if2, st_update_pc, st_decode,
    st_write_imm, st_get_b, st_get_a, st_alu, st_write_reg,
    st_addr_a, st_addr_c, st_load_addr, st_mem_read, st_write_mem,
    st_str_get_b, st_str_c, st_mem_write, st_halt
  } state_e;

endpackage

// ==== design/cpu_control.sv ====
`timescale 1ns/1ns

module cpu_control import risc_pkg::*; (
  input  logic       clk,
  input  logic       arst_n,
  input  opcode_e    opcode,   // from instruction register
  input  logic [1:0] op,
  output reg_sel_e   reg_sel,
  output logic       load_ir,
  output logic       reg_write,
  output wb_sel_e    wb_sel,
  output logic       load_a,
  output logic       load_b,
  output logic       load_c,
  output logic       load_flags,
  output logic       a_zero,
  output logic       b_imm,
  output logic       load_pc,
  output logic       reset_pc,
  output logic       load_addr,
  output logic       addr_sel,
  output mem_cmd_e   mem_cmd,
  output logic       halted
);

  state_e state, state_nxt;

  logic is_cmp;     // flags only, no write-back
  logic is_mov_imm;
  logic pass_b;     // mov reg and mvn ignore operand a

  // ir is stable for the whole instruction, so these act like state
  assign is_cmp     = (opcode == opc_alu) && (op == alu_cmp);
  assign is_mov_imm = (opcode == opc_mov) && (op == 2'b10);
  assign pass_b     = (opcode == opc_mov) || ((opcode == opc_alu) && (op == alu_mvn));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n)
      state <= st_reset;
    else
      state <= state_nxt;
  end

  // next state
  always_comb begin
    state_nxt = state;
    case (state)
      st_reset:     state_nxt = st_if1;
      st_if1:       state_nxt = st_if2;
      st_if2:       state_nxt = st_update_pc;
      st_update_pc: state_nxt = (opcode == opc_branch) ? st_if1 : st_decode; // branch done here
      st_decode: begin
        case (opcode)
          opc_mov:          state_nxt = is_mov_imm ? st_write_imm : st_get_b;
          opc_alu:          state_nxt = st_get_b;
          opc_ldr, opc_str: state_nxt = st_addr_a;
          opc_halt:         state_nxt = st_halt;
          default:          state_nxt = st_if1;  // undefined class runs as nop
        endcase
      end
      st_write_imm: state_nxt = st_if1;
      st_get_b:     state_nxt = st_get_a;
      st_get_a:     state_nxt = st_alu;
      st_alu:       state_nxt = is_cmp ? st_if1 : st_write_reg;
      st_write_reg: state_nxt = st_if1;
      st_addr_a:    state_nxt = st_addr_c;
      st_addr_c:    state_nxt = st_load_addr;
      st_load_addr: state_nxt = (opcode == opc_ldr) ? st_mem_read : st_str_get_b;
      st_mem_read:  state_nxt = st_write_mem;
      st_write_mem: state_nxt = st_if1;
      st_str_get_b: state_nxt = st_str_c;
      st_str_c:     state_nxt = st_mem_write;
      st_mem_write: state_nxt = st_if1;
      st_halt:      state_nxt = st_halt;  // only reset leaves
      default:      state_nxt = st_reset;
    endcase
  end

  // outputs, decoded from the current state
  always_comb begin
    reg_sel    = sel_rn;
    wb_sel     = wb_alu;
    mem_cmd    = mem_none;
    load_ir    = 1'b0;
    reg_write  = 1'b0;
    load_a     = 1'b0;
    load_b     = 1'b0;
    load_c     = 1'b0;
    load_flags = 1'b0;
    a_zero     = 1'b0;
    b_imm      = 1'b0;
    load_pc    = 1'b0;
    reset_pc   = 1'b0;
    load_addr  = 1'b0;
    addr_sel   = 1'b0;
    halted     = 1'b0;
    case (state)
      st_reset: reset_pc = 1'b1;
      st_if1: begin
        mem_cmd  = mem_read;
        addr_sel = 1'b1;
      end
      st_if2: begin
        mem_cmd  = mem_read;  // word from if1 edge on rdata now
        addr_sel = 1'b1;
        load_ir  = 1'b1;
      end
      st_update_pc: load_pc = 1'b1;
      st_write_imm: begin
        reg_sel   = sel_rn;
        wb_sel    = wb_imm;
        reg_write = 1'b1;
      end
      st_get_b: begin
        reg_sel = sel_rm;
        load_b  = 1'b1;
      end
      st_get_a, st_addr_a: begin
        reg_sel = sel_rn;
        load_a  = 1'b1;
      end
      st_alu: begin
        load_c     = 1'b1;
        load_flags = is_cmp;
        a_zero     = pass_b;
      end
      st_write_reg: begin
        reg_sel   = sel_rd;
        reg_write = 1'b1;
      end
      st_addr_c: begin
        b_imm  = 1'b1;  // rn + sximm5
        load_c = 1'b1;
      end
      st_load_addr: load_addr = 1'b1;
      st_mem_read:  mem_cmd = mem_read;  // data address reg on the bus
      st_write_mem: begin
        reg_sel   = sel_rd;
        wb_sel    = wb_mem;
        reg_write = 1'b1;
      end
      st_str_get_b: begin
        reg_sel = sel_rd;  // store data comes from rd
        load_b  = 1'b1;
      end
      st_str_c: begin
        a_zero = 1'b1;
        load_c = 1'b1;
      end
      st_mem_write: mem_cmd = mem_write;
      st_halt:      halted = 1'b1;
      default: ;
    endcase
  end

endmodule

// ==== design/instr_decoder.sv ====
`timescale 1ns/1ns

module instr_decoder import risc_pkg::*; (
  input  logic                 clk,
  input  logic                 load_ir,
  input  logic [word_w-1:0]    instr,      // memory read data
  input  reg_sel_e             reg_sel,
  output opcode_e              opcode,
  output logic [1:0]           op,
  output alu_op_e              alu_op,
  output shift_e               shift,
  output cond_e                cond,
  output logic                 is_branch,
  output logic [reg_idx_w-1:0] read_idx,
  output logic [reg_idx_w-1:0] write_idx,
  output logic [word_w-1:0]    sximm5,
  output logic [word_w-1:0]    sximm8
);

  logic [word_w-1:0]    ir;
  logic [reg_idx_w-1:0] reg_idx;
  logic                 is_mem;

  always_ff @(posedge clk) begin
    if (load_ir)
      ir <= instr;
  end

  assign opcode    = opcode_e'(ir[opcode_lsb +: 3]);
  assign op        = ir[op_lsb +: 2];
  assign cond      = cond_e'(ir[rn_lsb +: 3]);  // cond shares the rn bits
  assign is_branch = (opcode == opc_branch) && (op == 2'b00);
  assign is_mem    = (opcode == opc_ldr) || (opcode == opc_str);

  // mov and ldr/str always add, imm5 overlaps sh so no shift on memory ops
  assign alu_op = (opcode == opc_alu) ? alu_op_e'(op) : alu_add;
  assign shift  = is_mem ? sh_none : shift_e'(ir[sh_lsb +: 2]);

  assign sximm5 = {{(word_w-imm5_w){ir[imm5_w-1]}}, ir[imm5_w-1:0]};
  assign sximm8 = {{(word_w-imm8_w){ir[imm8_w-1]}}, ir[imm8_w-1:0]};

  always_comb begin
    case (reg_sel)
      sel_rd:  reg_idx = ir[rd_lsb +: reg_idx_w];
      sel_rm:  reg_idx = ir[rm_lsb +: reg_idx_w];
      default: reg_idx = ir[rn_lsb +: reg_idx_w];
    endcase
  end

  assign read_idx  = reg_idx;
  assign write_idx = reg_idx;  // one select drives both ports

endmodule

// ==== design/reg_file.sv ====
`timescale 1ns/1ns

module reg_file import risc_pkg::*; (
  input  logic                 clk,
  input  logic                 reg_write,
  input  logic [reg_idx_w-1:0] write_idx,
  input  logic [reg_idx_w-1:0] read_idx,
  input  wb_sel_e              wb_sel,
  input  logic [word_w-1:0]    c_in,       // alu result, register c
  input  logic [word_w-1:0]    sximm8,
  input  logic [word_w-1:0]    mem_rdata,
  output logic [word_w-1:0]    read_data
);

  logic [word_w-1:0] regs [2**reg_idx_w];
  logic [word_w-1:0] wdata;

  // write-back source
  always_comb begin
    case (wb_sel)
      wb_imm:  wdata = sximm8;
      wb_mem:  wdata = mem_rdata;
      default: wdata = c_in;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reg_write)
      regs[write_idx] <= wdata;
  end

  assign read_data = regs[read_idx];  // async read

endmodule

// ==== design/exec_unit.sv ====
`timescale 1ns/1ns

module exec_unit import risc_pkg::*; (
  input  logic              clk,
  input  logic              arst_n,
  input  logic [word_w-1:0] read_data,
  input  logic              load_a,
  input  logic              load_b,
  input  logic              load_c,
  input  logic              load_flags,
  input  logic              a_zero,    // pass b straight to c
  input  logic              b_imm,     // use sximm5 as second operand
  input  shift_e            shift,
  input  alu_op_e           alu_op,
  input  logic [word_w-1:0] sximm5,
  output logic [word_w-1:0] c_out,
  output logic              n,
  output logic              v,
  output logic              z
);

  logic [word_w-1:0] a_reg, b_reg;
  logic [word_w-1:0] b_sh, a_op, b_op, result;
  logic              sub_ovf;

  always_ff @(posedge clk) begin
    if (load_a) a_reg <= read_data;
    if (load_b) b_reg <= read_data;
    if (load_c) c_out <= result;
  end

  always_comb begin
    case (shift)
      sh_lsl:  b_sh = {b_reg[word_w-2:0], 1'b0};
      sh_lsr:  b_sh = {1'b0, b_reg[word_w-1:1]};
      sh_asr:  b_sh = {b_reg[word_w-1], b_reg[word_w-1:1]};  // keep sign
      default: b_sh = b_reg;
    endcase
  end

  assign a_op = a_zero ? '0 : a_reg;
  assign b_op = b_imm ? sximm5 : b_sh;

  always_comb begin
    case (alu_op)
      alu_cmp: result = a_op - b_op;
      alu_and: result = a_op & b_op;
      alu_mvn: result = ~b_op;
      default: result = a_op + b_op;
    endcase
  end

  // signs of a and b differ and result sign differs from a
  assign sub_ovf = (a_op[word_w-1] != b_op[word_w-1]) && (result[word_w-1] != a_op[word_w-1]);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      {n, v, z} <= 3'b000;
    end else if (load_flags) begin
      n <= result[word_w-1];
      v <= sub_ovf;
      z <= (result == '0);
    end
  end

endmodule

// ==== design/pc_unit.sv ====
`timescale 1ns/1ns

module pc_unit import risc_pkg::*; (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              load_pc,
  input  logic              reset_pc,
  input  logic              is_branch,
  input  cond_e             cond,
  input  logic [word_w-1:0] sximm8,
  input  logic              n,
  input  logic              v,
  input  logic              z,
  input  logic              load_addr,
  input  logic              addr_sel,   // 1 for fetch
  input  logic [word_w-1:0] c_in,
  output logic [addr_w-1:0] pc,
  output logic [addr_w-1:0] mem_addr
);

  logic              taken;
  logic [addr_w-1:0] pc_inc, pc_nxt;
  logic [addr_w-1:0] data_addr;

  always_comb begin
    case (cond)
      cond_al: taken = 1'b1;
      cond_eq: taken = z;
      cond_ne: taken = !z;
      cond_lt: taken = (n != v);
      cond_le: taken = (n != v) || z;
      default: taken = 1'b0;  // unused codes fall through
    endcase
  end

  assign pc_inc = pc + 1'b1;
  assign pc_nxt = (is_branch && taken) ? pc_inc + sximm8[addr_w-1:0] : pc_inc;  // wraps at 512

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n)
      pc <= '0;
    else if (reset_pc)
      pc <= '0;
    else if (load_pc)
      pc <= pc_nxt;
  end

  always_ff @(posedge clk) begin
    if (load_addr)
      data_addr <= c_in[addr_w-1:0];  // low bits of rn + imm5
  end

  assign mem_addr = addr_sel ? pc : data_addr;

endmodule

// ==== design/cpu_top.sv ====
`timescale 1ns/1ns

module cpu_top import risc_pkg::*; (
  input  logic              clk,
  input  logic              arst_n,
  input  logic [word_w-1:0] mem_rdata,
  output mem_cmd_e          mem_cmd,
  output logic [addr_w-1:0] mem_addr,
  output logic [word_w-1:0] mem_wdata,  // register c, also write-back and address source
  output logic              n,
  output logic              v,
  output logic              z,
  output logic [addr_w-1:0] pc,
  output logic              halted
);

  // controller strobes
  reg_sel_e reg_sel;
  wb_sel_e  wb_sel;
  logic     load_ir, reg_write;
  logic     load_a, load_b, load_c, load_flags, a_zero, b_imm;
  logic     load_pc, reset_pc, load_addr, addr_sel;

  // decoded fields
  opcode_e               opcode;
  logic [1:0]            op;
  alu_op_e               alu_op;
  shift_e                shift;
  cond_e                 cond;
  logic                  is_branch;
  logic [reg_idx_w-1:0]  read_idx, write_idx;
  logic [word_w-1:0]     sximm5, sximm8;

  logic [word_w-1:0]     read_data;  // register file to exec unit

  cpu_control control_i (
    .clk(clk), .arst_n(arst_n), .opcode(opcode), .op(op),
    .reg_sel(reg_sel), .load_ir(load_ir), .reg_write(reg_write), .wb_sel(wb_sel),
    .load_a(load_a), .load_b(load_b), .load_c(load_c), .load_flags(load_flags),
    .a_zero(a_zero), .b_imm(b_imm), .load_pc(load_pc), .reset_pc(reset_pc),
    .load_addr(load_addr), .addr_sel(addr_sel), .mem_cmd(mem_cmd), .halted(halted)
  );

  instr_decoder decoder_i (
    .clk(clk), .load_ir(load_ir), .instr(mem_rdata), .reg_sel(reg_sel),
    .opcode(opcode), .op(op), .alu_op(alu_op), .shift(shift), .cond(cond),
    .is_branch(is_branch), .read_idx(read_idx), .write_idx(write_idx),
    .sximm5(sximm5), .sximm8(sximm8)
  );

  reg_file reg_file_i (
    .clk(clk), .reg_write(reg_write), .write_idx(write_idx), .read_idx(read_idx),
    .wb_sel(wb_sel), .c_in(mem_wdata), .sximm8(sximm8), .mem_rdata(mem_rdata),
    .read_data(read_data)
  );

  exec_unit exec_i (
    .clk(clk), .arst_n(arst_n), .read_data(read_data), .load_a(load_a),
    .load_b(load_b), .load_c(load_c), .load_flags(load_flags), .a_zero(a_zero),
    .b_imm(b_imm), .shift(shift), .alu_op(alu_op), .sximm5(sximm5),
    .c_out(mem_wdata), .n(n), .v(v), .z(z)
  );

  pc_unit pc_i (
    .clk(clk), .arst_n(arst_n), .load_pc(load_pc), .reset_pc(reset_pc),
    .is_branch(is_branch), .cond(cond), .sximm8(sximm8), .n(n), .v(v), .z(z),
    .load_addr(load_addr), .addr_sel(addr_sel), .c_in(mem_wdata), .pc(pc),
    .mem_addr(mem_addr)
  );

endmodule

// ==== bench/cpu_assertions.sv ====
`timescale 1ns/1ns

module cpu_assertions import risc_pkg::*; (
  input logic              clk,
  input logic              arst_n,
  input mem_cmd_e          mem_cmd,
  input logic              halted,
  input logic [addr_w-1:0] pc
);

  int assert_fails = 0;  // read by the bench at the end

  // bus idle while reset is held
  idle_in_reset: assert property (@(posedge clk) !arst_n |-> mem_cmd == mem_none)
    else begin
      $error("memory command active during reset");
      assert_fails++;
    end

  halt_sticky: assert property (@(posedge clk) disable iff (!arst_n) halted |=> halted)
    else begin
      $error("halted dropped without reset");
      assert_fails++;
    end

  pc_frozen: assert property (@(posedge clk) disable iff (!arst_n) halted |=> $stable(pc))
    else begin
      $error("pc moved while halted");
      assert_fails++;
    end

  cmd_known: assert property (@(posedge clk) disable iff (!arst_n) !$isunknown(mem_cmd))
    else begin
      $error("memory command unknown");
      assert_fails++;
    end

endmodule

bind cpu_top cpu_assertions assert_i (
  .clk(clk), .arst_n(arst_n), .mem_cmd(mem_cmd), .halted(halted), .pc(pc)
);

// ==== bench/cpu_tb.sv ====
`timescale 1ns/1ns

module cpu_tb import risc_pkg::*; ();

  logic              clk;
  logic              arst_n;
  logic [word_w-1:0] mem_rdata;
  mem_cmd_e          mem_cmd;
  logic [addr_w-1:0] mem_addr, pc;
  logic [word_w-1:0] mem_wdata;
  logic              n, v, z, halted;

  logic [word_w-1:0] mem [2**addr_w];  // external 512-word memory
  mem_cmd_e          cmd_q = mem_none;  // bus as seen late in the cycle
  logic [addr_w-1:0] addr_q;
  logic [word_w-1:0] wdata_q;

  logic [31:0]       lcg_state = 32'h620f;
  int                prog_len;
  int                cycle_count = 0;
  int                cycle_limit = 20;  // grows with every program run
  logic [addr_w-1:0] src_addr [4], dst_addr [4];  // copy program layout
  logic [word_w-1:0] src_val [4];

  cpu_top dut_i (
    .clk(clk), .arst_n(arst_n), .mem_rdata(mem_rdata), .mem_cmd(mem_cmd),
    .mem_addr(mem_addr), .mem_wdata(mem_wdata), .n(n), .v(v), .z(z), .pc(pc),
    .halted(halted)
  );

  always #5 clk = ~clk;

  always @(negedge clk) begin
    cmd_q   = mem_cmd;
    addr_q  = mem_addr;
    wdata_q = mem_wdata;
  end

  // read data shows up one cycle after the read edge
  always @(posedge clk) begin
    #1;
    if (cmd_q == mem_read)
      mem_rdata = mem[addr_q];
    else if (cmd_q == mem_write)
      mem[addr_q] = wdata_q;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("Timeout: program did not halt within %0d cycles", cycle_limit);
      $display("SIMULATION FAILED");
      $fatal(1, "cycle limit reached");
    end
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // instruction words, field layout opcode op rn rd sh rm
  function automatic logic [15:0] mov_imm(logic [2:0] rn, logic [7:0] imm8);
    return {opc_mov, 2'b10, rn, imm8};
  endfunction

  function automatic logic [15:0] mov_reg(logic [2:0] rd, shift_e sh, logic [2:0] rm);
    return {opc_mov, 2'b00, 3'd0, rd, sh, rm};
  endfunction

  function automatic logic [15:0] alu_word(alu_op_e op, logic [2:0] rn, logic [2:0] rd,
                                           shift_e sh, logic [2:0] rm);
    return {opc_alu, op, rn, rd, sh, rm};
  endfunction

  function automatic logic [15:0] mem_word(opcode_e opc, logic [2:0] rn, logic [2:0] rd,
                                           logic [4:0] imm5);
    return {opc, 2'b00, rn, rd, imm5};  // ldr or str
  endfunction

  function automatic logic [15:0] branch_word(cond_e c, logic [7:0] off);
    return {opc_branch, 2'b00, c, off};
  endfunction

  function automatic logic [15:0] fill_word(int a);
    return {opc_halt, 4'h0, a[8:0]};  // stray fetch halts
  endfunction

  // reference one-place shift
  function automatic logic [15:0] shifted(logic [15:0] b, shift_e sh);
    case (sh)
      sh_lsl:  return b << 1;
      sh_lsr:  return b >> 1;
      sh_asr:  return {b[15], b[15:1]};
      default: return b;
    endcase
  endfunction

  task automatic check(string name, logic [15:0] actual, logic [15:0] expected);
    if (actual !== expected) begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
      $display("SIMULATION FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic start_program();
    int a;
    for (a = 0; a < 2**addr_w; a++)
      mem[a] = fill_word(a);
    prog_len = 0;
  endtask

  task automatic emit(logic [15:0] w);
    mem[prog_len] = w;
    prog_len++;
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #1 arst_n = 1'b0;
    repeat (3) @(posedge clk);
    #1 arst_n = 1'b1;
  endtask

  task automatic wait_halted();
    do @(negedge clk); while (!halted);
  endtask

  task automatic run_program();
    cycle_limit += 11 * prog_len + 20;  // worst case str plus reset
    apply_reset();
    wait_halted();
  endtask

  // flags of x - y by value range, not by bit rule
  task automatic cmp_model(input logic [15:0] x, y, output logic en, ev, ez);
    logic [15:0] diff;
    int          sd;
    diff = x - y;
    sd   = int'($signed(x)) - int'($signed(y));
    en   = diff[15];
    ez   = (diff == 16'd0);
    ev   = (sd > 32767) || (sd < -32768);
  endtask

  // r0 = mem[80], r1 = mem[81], then cmp r0, r1
  task automatic compare_operands(logic [15:0] x, logic [15:0] y);
    mem[80] = x;
    mem[81] = y;
    emit(mov_imm(3'd6, 8'd80));
    emit(mem_word(opc_ldr, 3'd6, 3'd0, 5'd0));
    emit(mem_word(opc_ldr, 3'd6, 3'd1, 5'd1));
    emit(alu_word(alu_cmp, 3'd0, 3'd0, sh_none, 3'd1));
  endtask

  task automatic alu_test();
    logic [31:0]       r;
    logic [15:0]       a, b, bs;
    logic [word_w-1:0] expect_q [$];
    shift_e            sh;
    int                k;
    r = next_rand();
    start_program();
    emit(mov_imm(3'd0, r[31:24]));
    emit(mov_imm(3'd1, r[23:16]));
    emit(mov_imm(3'd7, 8'h60));  // results at 96..111
    a = {{8{r[31]}}, r[31:24]};
    b = {{8{r[23]}}, r[23:16]};
    for (k = 0; k < 4; k++) begin
      sh = shift_e'(k);
      bs = shifted(b, sh);
      emit(alu_word(alu_add, 3'd0, 3'd2, sh, 3'd1));
      emit(mem_word(opc_str, 3'd7, 3'd2, 5'(4*k)));
      emit(alu_word(alu_and, 3'd0, 3'd3, sh, 3'd1));
      emit(mem_word(opc_str, 3'd7, 3'd3, 5'(4*k+1)));
      emit(alu_word(alu_mvn, 3'd0, 3'd4, sh, 3'd1));
      emit(mem_word(opc_str, 3'd7, 3'd4, 5'(4*k+2)));
      emit(mov_reg(3'd5, sh, 3'd1));
      emit(mem_word(opc_str, 3'd7, 3'd5, 5'(4*k+3)));
      expect_q.push_back(a + bs);
      expect_q.push_back(a & bs);
      expect_q.push_back(~bs);
      expect_q.push_back(bs);
    end
    emit({opc_halt, 13'd0});
    run_program();
    for (k = 0; k < 16; k++)
      check($sformatf("mem[%0d]", 96 + k), mem[96 + k], expect_q[k]);
  endtask

  task automatic cmp_case(logic [15:0] x, logic [15:0] y);
    logic en, ev, ez;
    start_program();
    compare_operands(x, y);
    emit({opc_halt, 13'd0});
    run_program();
    cmp_model(x, y, en, ev, ez);
    check("n", 16'(n), 16'(en));
    check("v", 16'(v), 16'(ev));
    check("z", 16'(z), 16'(ez));
  endtask

  task automatic branch_case(cond_e c, logic [15:0] x, logic [15:0] y);
    logic en, ev, ez, take;
    start_program();
    compare_operands(x, y);
    emit(mov_imm(3'd7, 8'h60));
    emit(mov_imm(3'd2, 8'h11));
    emit(mov_imm(3'd3, 8'h22));
    emit(branch_word(c, 8'd1));  // hop over the next word
    emit(mem_word(opc_str, 3'd7, 3'd2, 5'd0));  // not-taken marker
    emit(mem_word(opc_str, 3'd7, 3'd3, 5'd1));
    emit({opc_halt, 13'd0});
    run_program();
    cmp_model(x, y, en, ev, ez);
    case (c)
      cond_eq: take = ez;
      cond_ne: take = !ez;
      cond_lt: take = (en != ev);
      cond_le: take = (en != ev) || ez;
      default: take = 1'b1;
    endcase
    check($sformatf("mem[96] cond %0d", c), mem[96], take ? fill_word(96) : 16'h0011);
    check("mem[97]", mem[97], 16'h0022);
    check("pc", 16'(pc), 16'(prog_len));  // halt address + 1
  endtask

  task automatic branch_test();
    logic [15:0] xs [4] = '{16'd5, 16'd3, 16'd9, 16'h8000};
    logic [15:0] ys [4] = '{16'd5, 16'd9, 16'd3, 16'd1};  // eq, lt, gt, overflow
    int          ci, pi;
    for (ci = 0; ci < 5; ci++)
      for (pi = 0; pi < 4; pi++)
        branch_case(cond_e'(ci), xs[pi], ys[pi]);
  endtask

  // four ldr/str pairs with mixed-sign offsets
  task automatic build_copy_program();
    int          soff [4] = '{-3, 15, -16, 4};
    int          doff [4] = '{7, -16, 0, -1};
    logic [31:0] r;
    int          i;
    start_program();
    emit(mov_imm(3'd6, 8'd100));
    emit(mov_imm(3'd5, 8'ha0));  // sign extends, low bits 0x1a0
    for (i = 0; i < 4; i++) begin
      r           = next_rand();
      src_addr[i] = 9'(100 + soff[i]);
      dst_addr[i] = 9'(416 + doff[i]);
      src_val[i]  = r[31:16];
      mem[src_addr[i]] = r[31:16];
      emit(mem_word(opc_ldr, 3'd6, 3'(i), 5'(soff[i])));
      emit(mem_word(opc_str, 3'd5, 3'(i), 5'(doff[i])));
    end
    emit({opc_halt, 13'd0});
  endtask

  task automatic verify_copies();
    int i;
    for (i = 0; i < 4; i++)
      check($sformatf("mem[%0d]", dst_addr[i]), mem[dst_addr[i]], src_val[i]);
  endtask

  task automatic load_store_test();
    build_copy_program();
    run_program();
    verify_copies();
  endtask

  task automatic halt_reset_test();
    logic [addr_w-1:0] halt_pc;
    int                i;
    build_copy_program();
    cycle_limit += 11 * prog_len + 100;  // aborted run, rerun, idle watch
    apply_reset();
    repeat (30) @(negedge clk);
    apply_reset();
    for (i = 0; i < 4; i++)
      mem[dst_addr[i]] = fill_word(dst_addr[i]);  // wipe partial stores
    do @(negedge clk); while (mem_cmd != mem_read);
    check("mem_addr", 16'(mem_addr), 16'd0);  // first fetch after reset
    wait_halted();
    verify_copies();
    halt_pc = pc;
    repeat (50) begin
      @(negedge clk);
      check("mem_cmd", 16'(mem_cmd), 16'(mem_none));
      check("pc", 16'(pc), 16'(halt_pc));
    end
  endtask

  initial begin
    clk       = 1'b0;
    arst_n    = 1'b1;
    mem_rdata = '0;
    #1 arst_n = 1'b0;  // reset before the first edge
    alu_test();
    alu_test();
    cmp_case(16'd5, 16'd5);
    cmp_case(16'd3, 16'd9);
    cmp_case(16'd9, 16'd3);
    cmp_case(16'h8000, 16'h0001);
    cmp_case(16'h7fff, 16'hffff);
    cmp_case(next_rand() >> 16, 16'(next_rand()));
    load_store_test();
    branch_test();
    halt_reset_test();
    if (dut_i.assert_i.assert_fails == 0) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      $display("%0d assertion failures", dut_i.assert_i.assert_fails);
      $display("SIMULATION FAILED");
      $fatal(1, "assertions failed");
    end
  end

endmodule

// ==== flist.f ====
design/risc_pkg.sv
design/cpu_control.sv
design/instr_decoder.sv
design/reg_file.sv
design/exec_unit.sv
design/pc_unit.sv
design/cpu_top.sv
bench/cpu_assertions.sv
bench/cpu_tb.sv
